// ==== source/nand_pkg.sv ====
// shared definitions of the NAND controller, imported by the RTL modules and the testbench
package nand_pkg;

	// ----------------------------------------
	// host command codes
	// ----------------------------------------
	// codes left out of the list are ignored by the sequencer
	typedef enum logic [5:0] {
		CMD_NAND_RESET     = 6'd1,
		CMD_READ_ID        = 6'd3,
		CMD_READ_STATUS    = 6'd5,
		CMD_GET_STATUS     = 6'd8,
		CMD_CHIP_ENABLE    = 6'd9,
		CMD_CHIP_DISABLE   = 6'd10,
		CMD_WRITE_PROTECT  = 6'd11,
		CMD_WRITE_ENABLE   = 6'd12,
		CMD_RESET_INDEX    = 6'd13,
		CMD_GET_ID_BYTE    = 6'd14,
		CMD_BYPASS_ADDRESS = 6'd20,
		CMD_BYPASS_COMMAND = 6'd21,
		CMD_BYPASS_DATA_WR = 6'd22,
		CMD_BYPASS_DATA_RD = 6'd23
	} host_cmd_t;

	// which latch strobe goes with a write cycle
	typedef enum logic [1:0] {CYC_CMD, CYC_ADDR, CYC_DATA} cycle_kind_t;

	// ----------------------------------------
	// NAND opcodes and sizes
	// ----------------------------------------
	localparam logic [7:0] NAND_OP_RESET       = 8'hff;
	localparam logic [7:0] NAND_OP_READ_ID     = 8'h90;
	localparam logic [7:0] NAND_OP_READ_STATUS = 8'h70;
	localparam int ID_BYTES = 5;

	// strobe and delay timing, all in clock cycles
	localparam int T_WE_LOW  = 3;
	localparam int T_WE_HIGH = 2;
	localparam int T_RE_LOW  = 4;
	localparam int T_RE_HIGH = 2;
	localparam int T_WB      = 12;
	localparam int T_WHR     = 8;

	// counter widths
	localparam int PHASE_W = 3;
	localparam int DLY_W   = $clog2(T_WB + 1);
	localparam int IDX_W   = $clog2(ID_BYTES + 1);

	// status register bits, the rest read as zero
	localparam int ST_CE  = 2;
	localparam int ST_WP  = 3;
	localparam int ST_OOB = 4;
	// write protected out of reset
	localparam logic [7:0] STATUS_RESET = 8'h08;

endpackage

// ==== source/nand_cycle_if.sv ====
// start/done handshake between the sequencer and one NAND cycle generator
`timescale 1ns/1ps

interface nand_cycle_if;
	import nand_pkg::*;

	// sequencer side, start is a single cycle pulse
	logic        start;
	cycle_kind_t kind;
	logic [7:0]  wdata;

	// generator side, rdata only valid with done
	logic        busy;
	logic        done;
	logic [7:0]  rdata;

	modport ctrl (output start, output kind, output wdata,
		input busy, input done, input rdata);

	modport unit (input start, input kind, input wdata,
		output busy, output done, output rdata);

endinterface

// ==== source/nand_strobe_if.sv ====
// raw NAND strobes and data from one cycle generator towards the pin driver
`timescale 1ns/1ps

interface nand_strobe_if;

	// latch enables and write strobe
	logic       cle;
	logic       ale;
	logic       we_n;
	// read strobe
	logic       re_n;
	// outgoing byte and its enable
	logic [7:0] dout;
	logic       doe;
	// registered byte from the chip
	logic [7:0] din;

	modport src (output cle, output ale, output we_n, output re_n,
		output dout, output doe, input din);

	modport sink (input cle, input ale, input we_n, input re_n,
		input dout, input doe, output din);

endinterface

// ==== source/nand_sequencer.sv ====
// command interpreter of the NAND controller, runs host commands as sequences of NAND cycles
`timescale 1ns/1ps

module nand_sequencer (
	input  logic                clk,
	input  logic                nreset,
	input  logic                activate,
	input  nand_pkg::host_cmd_t cmd_in,
	input  logic [7:0]          data_in,
	input  logic                nand_rnb,
	output logic [7:0]          data_out,
	output logic                busy,
	output logic                nand_ce_n,
	output logic                nand_wp_n,
	nand_cycle_if.ctrl          wr,
	nand_cycle_if.ctrl          rd
);
	import nand_pkg::*;

	// main state, run -> wait for done -> delay and R/B# -> run
	typedef enum logic [1:0] {S_IDLE, S_RUN, S_WAIT, S_DELAY} state_t;
	// step inside a multi cycle operation
	typedef enum logic [1:0] {SS_BEGIN, SS_ADDR, SS_READ, SS_END} sub_t;

	state_t           state;
	sub_t             sub;
	host_cmd_t        op;
	logic [7:0]       arg;
	logic [DLY_W-1:0] dly;
	logic [IDX_W-1:0] idx;
	logic [IDX_W-1:0] byte_cnt;
	logic [7:0]       status;
	logic [7:0]       id_store [ID_BYTES];

	assign busy = (state != S_IDLE);

	// read unit has no use for these
	assign rd.kind  = CYC_DATA;
	assign rd.wdata = '0;

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state     <= S_IDLE;
			sub       <= SS_BEGIN;
			op        <= CMD_GET_STATUS;
			dly       <= '0;
			idx       <= '0;
			byte_cnt  <= '0;
			status    <= STATUS_RESET;
			nand_ce_n <= 1'b1;
			nand_wp_n <= 1'b0;
			wr.start  <= 1'b0;
			rd.start  <= 1'b0;
		end else begin
			// start strobes last one cycle
			wr.start <= 1'b0;
			rd.start <= 1'b0;
			case (state)
				S_IDLE: begin
					// host byte is latched with the command
					if (activate) begin
						op    <= cmd_in;
						arg   <= data_in;
						sub   <= SS_BEGIN;
						state <= S_RUN;
					end
				end
				S_WAIT: begin
					if (wr.done || rd.done) begin
						state <= S_DELAY;
					end
					// ID bytes go to the store, other reads to the host
					if (rd.done && op == CMD_READ_ID) begin
						byte_cnt <= byte_cnt + 1'b1;
					end else if (rd.done) begin
						data_out <= rd.rdata;
					end
				end
				S_DELAY: begin
					// count the delay first, then hold while the chip is busy
					if (dly != '0) begin
						dly <= dly - 1'b1;
					end else if (nand_rnb) begin
						state <= S_RUN;
					end
				end
				S_RUN: begin
					// most commands finish here
					state <= S_IDLE;
					sub   <= SS_BEGIN;
					dly   <= '0;
					case (op)
						CMD_NAND_RESET: begin
							if (sub == SS_BEGIN) begin
								wr.start <= 1'b1;
								wr.kind  <= CYC_CMD;
								wr.wdata <= NAND_OP_RESET;
								dly      <= DLY_W'(T_WB);
								sub      <= SS_END;
								state    <= S_WAIT;
							end
						end
						CMD_READ_ID: begin
							if (sub == SS_BEGIN) begin
								wr.start <= 1'b1;
								wr.kind  <= CYC_CMD;
								wr.wdata <= NAND_OP_READ_ID;
								sub      <= SS_ADDR;
								state    <= S_WAIT;
							end else if (sub == SS_ADDR) begin
								wr.start <= 1'b1;
								wr.kind  <= CYC_ADDR;
								wr.wdata <= 8'h00;
								dly      <= DLY_W'(T_WHR);
								byte_cnt <= '0;
								sub      <= SS_READ;
								state    <= S_WAIT;
							end else if (byte_cnt != IDX_W'(ID_BYTES)) begin
								rd.start <= 1'b1;
								sub      <= SS_READ;
								state    <= S_WAIT;
							end else begin
								// fresh ID, host reads from byte 0
								idx <= '0;
							end
						end
						CMD_READ_STATUS: begin
							if (sub == SS_BEGIN) begin
								wr.start <= 1'b1;
								wr.kind  <= CYC_CMD;
								wr.wdata <= NAND_OP_READ_STATUS;
								dly      <= DLY_W'(T_WHR);
								sub      <= SS_READ;
								state    <= S_WAIT;
							end else if (sub == SS_READ) begin
								rd.start <= 1'b1;
								sub      <= SS_END;
								state    <= S_WAIT;
							end
						end
						CMD_GET_STATUS: data_out <= status;
						CMD_CHIP_ENABLE: begin
							nand_ce_n     <= 1'b0;
							status[ST_CE] <= 1'b1;
						end
						CMD_CHIP_DISABLE: begin
							nand_ce_n     <= 1'b1;
							status[ST_CE] <= 1'b0;
						end
						CMD_WRITE_PROTECT: begin
							nand_wp_n     <= 1'b0;
							status[ST_WP] <= 1'b1;
						end
						CMD_WRITE_ENABLE: begin
							nand_wp_n     <= 1'b1;
							status[ST_WP] <= 1'b0;
						end
						CMD_RESET_INDEX: idx <= '0;
						CMD_GET_ID_BYTE: begin
							// past the last byte: zero, wrap and flag
							if (idx < IDX_W'(ID_BYTES)) begin
								data_out       <= id_store[idx];
								idx            <= idx + 1'b1;
								status[ST_OOB] <= 1'b0;
							end else begin
								data_out       <= 8'h00;
								idx            <= '0;
								status[ST_OOB] <= 1'b1;
							end
						end
						CMD_BYPASS_COMMAND, CMD_BYPASS_ADDRESS, CMD_BYPASS_DATA_WR: begin
							if (sub == SS_BEGIN) begin
								wr.start <= 1'b1;
								wr.wdata <= arg;
								sub      <= SS_END;
								state    <= S_WAIT;
								if (op == CMD_BYPASS_COMMAND) begin
									wr.kind <= CYC_CMD;
									dly     <= DLY_W'(T_WB);
								end else if (op == CMD_BYPASS_ADDRESS) begin
									wr.kind <= CYC_ADDR;
									dly     <= DLY_W'(T_WB);
								end else begin
									wr.kind <= CYC_DATA;
								end
							end
						end
						CMD_BYPASS_DATA_RD: begin
							if (sub == SS_BEGIN) begin
								rd.start <= 1'b1;
								sub      <= SS_END;
								state    <= S_WAIT;
							end
						end
						default: ;
					endcase
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// ID bytes land at the running byte count
	always_ff @(posedge clk) begin
		if (state == S_WAIT && rd.done && op == CMD_READ_ID) begin
			id_store[byte_cnt] <= rd.rdata;
		end
	end

	// ----------------------------------------
	// checks
	// ----------------------------------------
	// the host only sees the end once no NAND cycle is still running
	a_end_gen_idle: assert property (@(posedge clk) disable iff (!nreset)
		$fell(busy) |-> !wr.busy && !rd.busy);
	// generators only get a start while idle
	a_wr_start_idle: assert property (@(posedge clk) disable iff (!nreset)
		wr.start |-> !wr.busy);
	a_rd_start_idle: assert property (@(posedge clk) disable iff (!nreset)
		rd.start |-> !rd.busy);

endmodule

// ==== source/nand_write_cycle.sv ====
// write cycle generator, times one command, address or data byte onto the NAND strobes
`timescale 1ns/1ps

module nand_write_cycle (
	input  logic        clk,
	input  logic        nreset,
	nand_cycle_if.unit  cyc,
	nand_strobe_if.src  pins
);
	import nand_pkg::*;

	logic               active;
	logic [PHASE_W-1:0] phase;
	cycle_kind_t        kind_q;
	logic [7:0]         data_q;

	// phase 0 .. T_WE_LOW-1 has we_n low, the rest high
	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase  <= '0;
		end else if (!active) begin
			if (cyc.start) begin
				active <= 1'b1;
				phase  <= '0;
			end
		end else if (phase == PHASE_W'(T_WE_LOW + T_WE_HIGH - 1)) begin
			active <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// byte and kind held for the whole cycle
	always_ff @(posedge clk) begin
		if (cyc.start && !active) begin
			kind_q <= cyc.kind;
			data_q <= cyc.wdata;
		end
	end

	assign cyc.busy  = active;
	assign cyc.done  = active && (phase == PHASE_W'(T_WE_LOW + T_WE_HIGH - 1));
	assign cyc.rdata = '0;

	// data stays driven through the high phase for hold
	assign pins.we_n = !(active && (phase < PHASE_W'(T_WE_LOW)));
	assign pins.cle  = active && (kind_q == CYC_CMD);
	assign pins.ale  = active && (kind_q == CYC_ADDR);
	assign pins.re_n = 1'b1;
	assign pins.dout = data_q;
	assign pins.doe  = active;

	// an undefined kind would pass as a data cycle with no latch strobe
	a_kind_valid: assert property (@(posedge clk) disable iff (!nreset)
		cyc.start |-> cyc.kind inside {CYC_CMD, CYC_ADDR, CYC_DATA});

endmodule

// ==== source/nand_read_cycle.sv ====
// read cycle generator, pulses re_n and captures one byte from the chip per cycle
`timescale 1ns/1ps

module nand_read_cycle (
	input  logic        clk,
	input  logic        nreset,
	nand_cycle_if.unit  cyc,
	nand_strobe_if.src  pins
);
	import nand_pkg::*;

	logic               active;
	logic [PHASE_W-1:0] phase;
	logic [7:0]         rdata_q;

	// re_n low for T_RE_LOW phases then high for T_RE_HIGH
	always_ff @(posedge clk) begin
		if (!nreset) begin
			active <= 1'b0;
			phase  <= '0;
		end else if (!active) begin
			if (cyc.start) begin
				active <= 1'b1;
				phase  <= '0;
			end
		end else if (phase == PHASE_W'(T_RE_LOW + T_RE_HIGH - 1)) begin
			active <= 1'b0;
		end else begin
			phase <= phase + 1'b1;
		end
	end

	// sample in the last low phase, data has settled by then
	always_ff @(posedge clk) begin
		if (active && phase == PHASE_W'(T_RE_LOW - 1)) begin
			rdata_q <= pins.din;
		end
	end

	assign cyc.busy  = active;
	assign cyc.done  = active && (phase == PHASE_W'(T_RE_LOW + T_RE_HIGH - 1));
	assign cyc.rdata = rdata_q;

	// only re_n moves, the write side stays idle
	assign pins.re_n = !(active && (phase < PHASE_W'(T_RE_LOW)));
	assign pins.cle  = 1'b0;
	assign pins.ale  = 1'b0;
	assign pins.we_n = 1'b1;
	assign pins.dout = '0;
	assign pins.doe  = 1'b0;

endmodule

// ==== source/nand_pin_driver.sv ====
// merges both cycle generators onto registered NAND pins and registers the incoming byte
`timescale 1ns/1ps

module nand_pin_driver (
	input  logic        clk,
	input  logic        nreset,
	input  logic [7:0]  nand_din,
	nand_strobe_if.sink wr_pins,
	nand_strobe_if.sink rd_pins,
	output logic        nand_cle,
	output logic        nand_ale,
	output logic        nand_we_n,
	output logic        nand_re_n,
	output logic [7:0]  nand_dout,
	output logic        nand_doe
);

	logic [7:0] din_q;

	// idle generators drive inactive levels, so a plain or / and merges them
	always_ff @(posedge clk) begin
		if (!nreset) begin
			nand_cle  <= 1'b0;
			nand_ale  <= 1'b0;
			nand_we_n <= 1'b1;
			nand_re_n <= 1'b1;
			nand_doe  <= 1'b0;
		end else begin
			nand_cle  <= wr_pins.cle | rd_pins.cle;
			nand_ale  <= wr_pins.ale | rd_pins.ale;
			nand_we_n <= wr_pins.we_n & rd_pins.we_n;
			nand_re_n <= wr_pins.re_n & rd_pins.re_n;
			nand_doe  <= wr_pins.doe | rd_pins.doe;
		end
	end

	// data path, one stage each way
	always_ff @(posedge clk) begin
		nand_dout <= wr_pins.doe ? wr_pins.dout : rd_pins.dout;
		din_q     <= nand_din;
	end

	assign wr_pins.din = din_q;
	assign rd_pins.din = din_q;

	// sequencer runs one generator at a time, so we_n and re_n never overlap
	a_strobe_excl: assert property (@(posedge clk) disable iff (!nreset)
		!(!(wr_pins.we_n & rd_pins.we_n) && !(wr_pins.re_n & rd_pins.re_n)));

endmodule

// ==== source/nand_master.sv ====
// top level of the NAND flash controller, connects the sequencer, cycle generators and pins
`timescale 1ns/1ps

module nand_master (
	input  logic                clk,
	input  logic                nreset,
	// host side
	input  logic                activate,
	input  nand_pkg::host_cmd_t cmd_in,
	input  logic [7:0]          data_in,
	output logic [7:0]          data_out,
	output logic                busy,
	// NAND chip side
	input  logic                nand_rnb,
	input  logic [7:0]          nand_din,
	output logic                nand_cle,
	output logic                nand_ale,
	output logic                nand_we_n,
	output logic                nand_re_n,
	output logic                nand_ce_n,
	output logic                nand_wp_n,
	output logic [7:0]          nand_dout,
	output logic                nand_doe
);

	// one handshake and one strobe bundle per generator
	nand_cycle_if  wr_cyc ();
	nand_cycle_if  rd_cyc ();
	nand_strobe_if wr_strb ();
	nand_strobe_if rd_strb ();

	nand_sequencer i_sequencer (
		.clk       (clk),
		.nreset    (nreset),
		.activate  (activate),
		.cmd_in    (cmd_in),
		.data_in   (data_in),
		.nand_rnb  (nand_rnb),
		.data_out  (data_out),
		.busy      (busy),
		.nand_ce_n (nand_ce_n),
		.nand_wp_n (nand_wp_n),
		.wr        (wr_cyc),
		.rd        (rd_cyc)
	);

	nand_write_cycle i_write_cycle (.clk(clk), .nreset(nreset), .cyc(wr_cyc), .pins(wr_strb));

	nand_read_cycle i_read_cycle (.clk(clk), .nreset(nreset), .cyc(rd_cyc), .pins(rd_strb));

	nand_pin_driver i_pin_driver (
		.clk       (clk),
		.nreset    (nreset),
		.nand_din  (nand_din),
		.wr_pins   (wr_strb),
		.rd_pins   (rd_strb),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_we_n (nand_we_n),
		.nand_re_n (nand_re_n),
		.nand_dout (nand_dout),
		.nand_doe  (nand_doe)
	);

endmodule

// ==== tb/tb_clock_gen.sv ====
// testbench clock and reset source, 8 ns clock with reset held low for the first cycles
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 8,
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic nreset
);

	// free running clock
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		nreset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		nreset <= 1'b1;
	end

endmodule

// ==== tb/tb_flash_model.sv ====
// behavioral NAND chip for the testbench, latches written bytes and serves ID, status and array data
`timescale 1ns/1ps

module tb_flash_model #(
	parameter logic [31:0] SEED = 32'hb8e7_4b16
) (
	input  logic       clk,
	input  logic       nreset,
	input  logic       nand_ce_n,
	input  logic       nand_cle,
	input  logic       nand_ale,
	input  logic       nand_we_n,
	input  logic       nand_re_n,
	input  logic [7:0] nand_dout,
	output logic       nand_rnb,
	output logic [7:0] nand_din
);
	import nand_pkg::*;

	// what the next read returns
	typedef enum logic [1:0] {M_ARRAY, M_ID, M_STATUS} mode_t;

	localparam int LOG_DEPTH   = 1024;
	localparam int BUSY_CYCLES = 20;

	// chip contents, fixed at start
	logic [7:0]  id_bytes [ID_BYTES];
	logic [7:0]  status_byte;
	logic [7:0]  mem [256];
	integer      seed;

	// record of every latched byte
	cycle_kind_t log_kind [LOG_DEPTH];
	logic [7:0]  log_byte [LOG_DEPTH];
	int          log_cnt;

	mode_t       mode;
	logic [7:0]  arr_ptr;
	int          id_ptr;
	int          busy_cnt;
	logic        we_q;
	logic        re_q;
	cycle_kind_t latch_kind;

	initial begin
		seed = SEED;
		for (int i = 0; i < ID_BYTES; i++) begin
			id_bytes[i] = 8'($random(seed));
		end
		status_byte = 8'($random(seed));
		// random fill mixed with the address
		for (int a = 0; a < 256; a++) begin
			mem[a] = 8'($random(seed)) ^ 8'(a);
		end
	end

	// latch strobes decide the kind of byte
	assign latch_kind = nand_cle ? CYC_CMD : (nand_ale ? CYC_ADDR : CYC_DATA);

	// ----------------------------------------
	// write latch, read pointer and R/B#
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!nreset) begin
			we_q     <= 1'b1;
			re_q     <= 1'b1;
			mode     <= M_ARRAY;
			arr_ptr  <= '0;
			id_ptr   <= 0;
			busy_cnt <= 0;
			log_cnt  <= 0;
		end else begin
			we_q <= nand_we_n;
			re_q <= nand_re_n;
			if (busy_cnt != 0) begin
				busy_cnt <= busy_cnt - 1;
			end
			// rising we_n with the chip selected
			if (nand_we_n && !we_q && !nand_ce_n) begin
				if (log_cnt < LOG_DEPTH) begin
					log_kind[log_cnt] <= latch_kind;
					log_byte[log_cnt] <= nand_dout;
					log_cnt           <= log_cnt + 1;
				end
				if (nand_cle) begin
					if (nand_dout == NAND_OP_READ_ID) begin
						mode   <= M_ID;
						id_ptr <= 0;
					end else if (nand_dout == NAND_OP_READ_STATUS) begin
						mode <= M_STATUS;
					end else begin
						mode <= M_ARRAY;
					end
					// reset keeps the chip busy for a while
					if (nand_dout == NAND_OP_RESET) begin
						busy_cnt <= BUSY_CYCLES;
					end
				end
			end
			// rising re_n moves on to the next byte
			if (nand_re_n && !re_q && !nand_ce_n) begin
				if (mode == M_ID) begin
					id_ptr <= id_ptr + 1;
				end else if (mode == M_ARRAY) begin
					arr_ptr <= arr_ptr + 1'b1;
				end
			end
		end
	end

	assign nand_rnb = (busy_cnt == 0);

	// deselected chip reads as zero
	always_comb begin
		if (nand_ce_n) begin
			nand_din = 8'h00;
		end else if (mode == M_ID) begin
			nand_din = (id_ptr < ID_BYTES) ? id_bytes[id_ptr] : 8'h00;
		end else if (mode == M_STATUS) begin
			nand_din = status_byte;
		end else begin
			nand_din = mem[arr_ptr];
		end
	end

endmodule

// ==== tb/tb_nand_master.sv ====
// top testbench of the NAND controller, directed and random host commands checked against a model
`timescale 1ns/1ps

module tb_nand_master;
	import nand_pkg::*;

	localparam int MAX_CMDS       = 200;
	localparam int CYCLES_PER_CMD = 150;
	localparam int CYCLE_LIMIT    = MAX_CMDS * CYCLES_PER_CMD;
	// the directed part issues 29 commands
	localparam int N_DIRECTED     = 29;
	localparam int N_RANDOM       = MAX_CMDS - N_DIRECTED;

	logic       clk;
	logic       nreset;
	logic       activate;
	host_cmd_t  cmd_in;
	logic [7:0] data_in;
	logic [7:0] data_out;
	logic       busy;
	logic       nand_rnb;
	logic [7:0] nand_din;
	logic       nand_cle;
	logic       nand_ale;
	logic       nand_we_n;
	logic       nand_re_n;
	logic       nand_ce_n;
	logic       nand_wp_n;
	logic [7:0] nand_dout;
	logic       nand_doe;

	// reference model of the controller
	logic [7:0] exp_status;
	int         exp_idx;
	logic       exp_ce_n;
	logic       exp_wp_n;
	logic [7:0] exp_id [ID_BYTES];

	integer     seed;
	int         cycles = 0;
	int         k;
	int         n;
	logic [7:0] rnd_byte;

	tb_clock_gen i_clock (.clk(clk), .nreset(nreset));

	tb_flash_model #(.SEED(32'hb8e7_4b16)) i_flash (
		.clk       (clk),
		.nreset    (nreset),
		.nand_ce_n (nand_ce_n),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_we_n (nand_we_n),
		.nand_re_n (nand_re_n),
		.nand_dout (nand_dout),
		.nand_rnb  (nand_rnb),
		.nand_din  (nand_din)
	);

	nand_master i_dut (
		.clk       (clk),
		.nreset    (nreset),
		.activate  (activate),
		.cmd_in    (cmd_in),
		.data_in   (data_in),
		.data_out  (data_out),
		.busy      (busy),
		.nand_rnb  (nand_rnb),
		.nand_din  (nand_din),
		.nand_cle  (nand_cle),
		.nand_ale  (nand_ale),
		.nand_we_n (nand_we_n),
		.nand_re_n (nand_re_n),
		.nand_ce_n (nand_ce_n),
		.nand_wp_n (nand_wp_n),
		.nand_dout (nand_dout),
		.nand_doe  (nand_doe)
	);

	// ----------------------------------------
	// checking helpers
	// ----------------------------------------
	task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task check_entry(input int pos, input cycle_kind_t kind, input logic [7:0] b);
		check_value("latched cycle kind", 32'(i_flash.log_kind[pos]), 32'(kind));
		check_value("latched byte", 32'(i_flash.log_byte[pos]), 32'(b));
	endtask

	// bytes the chip should latch for one command
	function automatic int bytes_latched_by(input host_cmd_t c, input logic ce_n);
		if (ce_n) begin
			return 0;
		end
		case (c)
			CMD_READ_ID: return 2;
			CMD_NAND_RESET, CMD_READ_STATUS: return 1;
			CMD_BYPASS_COMMAND, CMD_BYPASS_ADDRESS, CMD_BYPASS_DATA_WR: return 1;
			default: return 0;
		endcase
	endfunction

	function automatic host_cmd_t pick_command(input int sel);
		case (sel)
			0:  return CMD_NAND_RESET;
			1:  return CMD_READ_ID;
			2:  return CMD_READ_STATUS;
			3:  return CMD_GET_STATUS;
			4:  return CMD_CHIP_ENABLE;
			5:  return CMD_CHIP_DISABLE;
			6:  return CMD_WRITE_PROTECT;
			7:  return CMD_WRITE_ENABLE;
			8:  return CMD_RESET_INDEX;
			9:  return CMD_GET_ID_BYTE;
			10: return CMD_BYPASS_COMMAND;
			11: return CMD_BYPASS_ADDRESS;
			12: return CMD_BYPASS_DATA_WR;
			default: return CMD_BYPASS_DATA_RD;
		endcase
	endfunction

	// one host handshake, called right after a rising edge
	task issue(input host_cmd_t c, input logic [7:0] d);
		activate <= 1'b1;
		cmd_in   <= c;
		data_in  <= d;
		@(posedge clk);
		activate <= 1'b0;
		@(posedge clk);
		check_value("busy after activate", 32'(busy), 32'h1);
		while (busy) @(posedge clk);
	endtask

	// run a command and compare it with the reference model
	task run_command(input host_cmd_t c, input logic [7:0] d);
		int         log_before;
		int         n_new;
		int         i;
		logic [7:0] chip_byte;
		log_before = i_flash.log_cnt;
		n_new      = bytes_latched_by(c, exp_ce_n);
		// the byte the chip would serve next
		chip_byte  = nand_din;
		issue(c, d);
		check_value("latched byte count", 32'(i_flash.log_cnt), 32'(log_before + n_new));
		case (c)
			CMD_NAND_RESET: begin
				if (!exp_ce_n) check_entry(log_before, CYC_CMD, NAND_OP_RESET);
			end
			CMD_READ_ID: begin
				if (!exp_ce_n) begin
					check_entry(log_before, CYC_CMD, NAND_OP_READ_ID);
					check_entry(log_before + 1, CYC_ADDR, 8'h00);
				end
				for (i = 0; i < ID_BYTES; i++) begin
					exp_id[i] = exp_ce_n ? 8'h00 : i_flash.id_bytes[i];
				end
				exp_idx = 0;
			end
			CMD_READ_STATUS: begin
				if (!exp_ce_n) check_entry(log_before, CYC_CMD, NAND_OP_READ_STATUS);
				chip_byte = exp_ce_n ? 8'h00 : i_flash.status_byte;
				check_value("status byte from chip", 32'(data_out), 32'(chip_byte));
			end
			CMD_GET_STATUS: check_value("status register", 32'(data_out), 32'(exp_status));
			CMD_CHIP_ENABLE: begin
				exp_ce_n          = 1'b0;
				exp_status[ST_CE] = 1'b1;
			end
			CMD_CHIP_DISABLE: begin
				exp_ce_n          = 1'b1;
				exp_status[ST_CE] = 1'b0;
			end
			CMD_WRITE_PROTECT: begin
				exp_wp_n          = 1'b0;
				exp_status[ST_WP] = 1'b1;
			end
			CMD_WRITE_ENABLE: begin
				exp_wp_n          = 1'b1;
				exp_status[ST_WP] = 1'b0;
			end
			CMD_RESET_INDEX: exp_idx = 0;
			CMD_GET_ID_BYTE: begin
				// one past the end reads zero and wraps
				if (exp_idx < ID_BYTES) begin
					check_value("ID byte", 32'(data_out), 32'(exp_id[exp_idx]));
					exp_idx            = exp_idx + 1;
					exp_status[ST_OOB] = 1'b0;
				end else begin
					check_value("ID byte out of range", 32'(data_out), 32'h0);
					exp_idx            = 0;
					exp_status[ST_OOB] = 1'b1;
				end
			end
			CMD_BYPASS_COMMAND: if (!exp_ce_n) check_entry(log_before, CYC_CMD, d);
			CMD_BYPASS_ADDRESS: if (!exp_ce_n) check_entry(log_before, CYC_ADDR, d);
			CMD_BYPASS_DATA_WR: if (!exp_ce_n) check_entry(log_before, CYC_DATA, d);
			CMD_BYPASS_DATA_RD: check_value("bypass read", 32'(data_out), 32'(chip_byte));
			default: ;
		endcase
		check_value("nand_ce_n", 32'(nand_ce_n), 32'(exp_ce_n));
		check_value("nand_wp_n", 32'(nand_wp_n), 32'(exp_wp_n));
	endtask

	// ----------------------------------------
	// monitors
	// ----------------------------------------
	// chip busy must hold the controller busy
	always @(posedge clk) begin
		if (nreset === 1'b1 && nand_rnb === 1'b0) begin
			check_value("busy while R/B# low", 32'(busy), 32'h1);
		end
	end

	// bus driven during a write strobe, released during a read strobe
	always @(posedge clk) begin
		if (nreset === 1'b1 && nand_we_n === 1'b0) begin
			check_value("nand_doe during write", 32'(nand_doe), 32'h1);
		end
		if (nreset === 1'b1 && nand_re_n === 1'b0) begin
			check_value("nand_doe during read", 32'(nand_doe), 32'h0);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: no result after %0d clock cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation timeout");
		end
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		activate   = 1'b0;
		cmd_in     = CMD_GET_STATUS;
		data_in    = 8'h00;
		seed       = 32'hb8e7_4b16;
		exp_status = STATUS_RESET;
		exp_idx    = 0;
		exp_ce_n   = 1'b1;
		exp_wp_n   = 1'b0;
		for (k = 0; k < ID_BYTES; k++) begin
			exp_id[k] = 8'h00;
		end
		wait (nreset === 1'b1);
		@(posedge clk);

		// idle pins out of reset
		check_value("busy after reset", 32'(busy), 32'h0);
		check_value("nand_ce_n after reset", 32'(nand_ce_n), 32'h1);
		check_value("nand_wp_n after reset", 32'(nand_wp_n), 32'h0);
		check_value("nand_we_n after reset", 32'(nand_we_n), 32'h1);
		check_value("nand_re_n after reset", 32'(nand_re_n), 32'h1);
		check_value("nand_cle after reset", 32'(nand_cle), 32'h0);
		check_value("nand_ale after reset", 32'(nand_ale), 32'h0);
		check_value("nand_doe after reset", 32'(nand_doe), 32'h0);
		run_command(CMD_GET_STATUS, 8'h00);

		// chip enable and write protect with status readback
		run_command(CMD_CHIP_ENABLE, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_WRITE_ENABLE, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_WRITE_PROTECT, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_CHIP_DISABLE, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_CHIP_ENABLE, 8'h00);

		// ID read and overrun, then a restart from byte 0 with the index away from zero
		run_command(CMD_READ_ID, 8'h00);
		repeat (ID_BYTES + 1) run_command(CMD_GET_ID_BYTE, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_GET_ID_BYTE, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);
		run_command(CMD_RESET_INDEX, 8'h00);
		run_command(CMD_GET_ID_BYTE, 8'h00);

		run_command(CMD_READ_STATUS, 8'h00);

		// bypass path with random bytes
		rnd_byte = 8'($random(seed));
		run_command(CMD_BYPASS_COMMAND, rnd_byte);
		rnd_byte = 8'($random(seed));
		run_command(CMD_BYPASS_ADDRESS, rnd_byte);
		rnd_byte = 8'($random(seed));
		run_command(CMD_BYPASS_DATA_WR, rnd_byte);
		run_command(CMD_BYPASS_DATA_RD, 8'h00);

		// reset with R/B# low, then a normal command
		run_command(CMD_NAND_RESET, 8'h00);
		run_command(CMD_GET_STATUS, 8'h00);

		// random command order
		for (n = 0; n < N_RANDOM; n++) begin
			k        = $unsigned($random(seed)) % 14;
			rnd_byte = 8'($random(seed));
			run_command(pick_command(k), rnd_byte);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== nand_master.f ====
source/nand_pkg.sv
source/nand_cycle_if.sv
source/nand_strobe_if.sv
source/nand_sequencer.sv
source/nand_write_cycle.sv
source/nand_read_cycle.sv
source/nand_pin_driver.sv
source/nand_master.sv
tb/tb_clock_gen.sv
tb/tb_flash_model.sv
tb/tb_nand_master.sv

// ==== Makefile ====
# Verilator lint and simulation of the NAND flash controller

TOOL     := verilator
FLAGS    := --timing --assert -Wno-fatal
TOP      := tb_nand_master
FILELIST := nand_master.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	-./$(BUILD)/$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
